// ==== logic/vlane_cfg.svh ====
`ifndef VLANE_CFG_SVH
`define VLANE_CFG_SVH

// Lane and slice widths
`define VLANE_LLEN        64
`define VLANE_SLICE_W     32
`define VLANE_SLICES      (`VLANE_LLEN / `VLANE_SLICE_W)

// One mask bit per byte element of the full lane
`define VLANE_MASK_W      (`VLANE_LLEN / 8)

// Element counts per slice
`define VLANE_SLICE_BYTES (`VLANE_SLICE_W / 8)
`define VLANE_SLICE_ELEMS `VLANE_SLICE_BYTES

`endif

// ==== logic/vlane_pkg.sv ====
package vlane_pkg;

`include "vlane_cfg.svh"

    // Element width
    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } vsew_e;

    // Lane opcodes
    typedef enum logic [4:0] {
        VADD,   VSUB,   VRSUB,
        VAND,   VOR,    VXOR,
        VSLL,   VSRL,   VSRA,
        VMIN,   VMINU,  VMAX,   VMAXU,
        VMERGE,
        VMSEQ,  VMSNE,  VMSLTU, VMSLT,
        VMSLEU, VMSLE,  VMSGTU, VMSGT
    } vop_e;

    typedef logic [`VLANE_LLEN-1:0]    lane_t;
    typedef logic [`VLANE_SLICE_W-1:0] slice_t;
    typedef logic [`VLANE_MASK_W-1:0]  mask_t;

    localparam int SLICE_IDX_W = (`VLANE_SLICES > 1) ? $clog2(`VLANE_SLICES) : 1;

    typedef logic [SLICE_IDX_W-1:0] slice_idx_t;

endpackage

// ==== logic/lane_slice_counter.sv ====
`timescale 1ns/10ps

`include "vlane_cfg.svh"

module lane_slice_counter (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  enable_i,
    output vlane_pkg::slice_idx_t slice_o,
    output logic                  hold_o
);

    localparam vlane_pkg::slice_idx_t LAST_IDX = vlane_pkg::slice_idx_t'(`VLANE_SLICES - 1);

    ////////////////////////////////////////
    // Slice index
    ////////////////////////////////////////

    // Steps once per enabled cycle, wraps after the last slice
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            slice_o <= '0;
        end
        else if (!enable_i || slice_o == LAST_IDX) begin
            slice_o <= '0;
        end
        else begin
            slice_o <= slice_o + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Hold level
    ////////////////////////////////////////

    // Caller keeps its inputs until the last slice is reached
    assign hold_o = enable_i && (slice_o < LAST_IDX);

endmodule

// ==== logic/lane_adder.sv ====
`timescale 1ns/10ps

`include "vlane_cfg.svh"

module lane_adder (
    input  vlane_pkg::vop_e   op_i,
    input  vlane_pkg::vsew_e  vsew_i,
    input  vlane_pkg::slice_t first_i,
    input  vlane_pkg::slice_t second_i,
    output vlane_pkg::slice_t sum_o
);

    localparam int BYTES = `VLANE_SLICE_BYTES;

    logic              is_sub;
    vlane_pkg::slice_t summand_a;
    vlane_pkg::slice_t summand_b;

    ////////////////////////////////////////
    // Summand selection
    ////////////////////////////////////////

    assign is_sub = (op_i == vlane_pkg::VSUB) || (op_i == vlane_pkg::VRSUB);

    // Reverse subtract swaps the roles of the operands
    always_comb begin
        if (op_i == vlane_pkg::VRSUB) begin
            summand_a = second_i;
            summand_b = ~first_i;
        end
        else if (is_sub) begin
            summand_a = first_i;
            summand_b = ~second_i;
        end
        else begin
            summand_a = first_i;
            summand_b = second_i;
        end
    end

    ////////////////////////////////////////
    // Segmented byte adder
    ////////////////////////////////////////

    // The +1 of the two's complement enters at each element's low byte
    always_comb begin
        logic       carry;
        logic       elem_start;
        logic [8:0] byte_sum;
        carry = 1'b0;
        for (int i = 0; i < BYTES; i++) begin
            case (vsew_i)
                vlane_pkg::EW8:  elem_start = 1'b1;
                vlane_pkg::EW16: elem_start = (i % 2) == 0;
                default:         elem_start = (i % 4) == 0;
            endcase
            if (elem_start) begin
                carry = is_sub;
            end
            byte_sum = {1'b0, summand_a[8*i +: 8]} + {1'b0, summand_b[8*i +: 8]}
                       + {8'b0, carry};
            sum_o[8*i +: 8] = byte_sum[7:0];
            carry = byte_sum[8];
        end
    end

endmodule

// ==== logic/lane_shifter.sv ====
`timescale 1ns/10ps

module lane_shifter (
    input  vlane_pkg::vop_e   op_i,
    input  vlane_pkg::vsew_e  vsew_i,
    input  vlane_pkg::slice_t first_i,
    input  vlane_pkg::slice_t second_i,
    output vlane_pkg::slice_t shift_o
);

    logic shift_left;
    logic shift_arith;

    assign shift_left  = (op_i == vlane_pkg::VSLL);
    assign shift_arith = (op_i == vlane_pkg::VSRA);

    ////////////////////////////////////////
    // Per-element shifts
    ////////////////////////////////////////

    // Amount is the low bits of the matching element of second
    always_comb begin
        case (vsew_i)
            vlane_pkg::EW8: begin
                for (int i = 0; i < 4; i++) begin
                    if (shift_left) begin
                        shift_o[8*i +: 8] = first_i[8*i +: 8] << second_i[8*i +: 3];
                    end
                    else if (shift_arith) begin
                        shift_o[8*i +: 8] = $signed(first_i[8*i +: 8]) >>> second_i[8*i +: 3];
                    end
                    else begin
                        shift_o[8*i +: 8] = first_i[8*i +: 8] >> second_i[8*i +: 3];
                    end
                end
            end
            vlane_pkg::EW16: begin
                for (int i = 0; i < 2; i++) begin
                    if (shift_left) begin
                        shift_o[16*i +: 16] = first_i[16*i +: 16] << second_i[16*i +: 4];
                    end
                    else if (shift_arith) begin
                        shift_o[16*i +: 16] = $signed(first_i[16*i +: 16]) >>> second_i[16*i +: 4];
                    end
                    else begin
                        shift_o[16*i +: 16] = first_i[16*i +: 16] >> second_i[16*i +: 4];
                    end
                end
            end
            default: begin
                if (shift_left) begin
                    shift_o = first_i << second_i[4:0];
                end
                else if (shift_arith) begin
                    shift_o = $signed(first_i) >>> second_i[4:0];
                end
                else begin
                    shift_o = first_i >> second_i[4:0];
                end
            end
        endcase
    end

endmodule

// ==== logic/lane_compare.sv ====
`timescale 1ns/10ps

module lane_compare (
    input  vlane_pkg::vop_e   op_i,
    input  vlane_pkg::vsew_e  vsew_i,
    input  vlane_pkg::slice_t first_i,
    input  vlane_pkg::slice_t second_i,
    output logic [3:0]        cmp_o,
    output vlane_pkg::slice_t minmax_o
);

    logic [3:0] eq_8b;
    logic [3:0] gtu_8b;
    logic [3:0] gts_8b;
    logic [1:0] eq_16b;
    logic [1:0] gtu_16b;
    logic [1:0] gts_16b;
    logic       eq_32b;
    logic       gtu_32b;
    logic       gts_32b;

    // Flags of the current width in the low bits
    logic [3:0] eq_w;
    logic [3:0] gtu_w;
    logic [3:0] gts_w;
    logic [3:0] elem_valid;
    logic [3:0] cmp_sel;

    ////////////////////////////////////////
    // Flags at all widths
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            eq_8b[i]  = first_i[8*i +: 8] == second_i[8*i +: 8];
            gtu_8b[i] = first_i[8*i +: 8] >  second_i[8*i +: 8];
            gts_8b[i] = $signed(first_i[8*i +: 8]) > $signed(second_i[8*i +: 8]);
        end
        for (int i = 0; i < 2; i++) begin
            eq_16b[i]  = first_i[16*i +: 16] == second_i[16*i +: 16];
            gtu_16b[i] = first_i[16*i +: 16] >  second_i[16*i +: 16];
            gts_16b[i] = $signed(first_i[16*i +: 16]) > $signed(second_i[16*i +: 16]);
        end
        eq_32b  = first_i == second_i;
        gtu_32b = first_i >  second_i;
        gts_32b = $signed(first_i) > $signed(second_i);
    end

    always_comb begin
        case (vsew_i)
            vlane_pkg::EW8: begin
                eq_w       = eq_8b;
                gtu_w      = gtu_8b;
                gts_w      = gts_8b;
                elem_valid = 4'b1111;
            end
            vlane_pkg::EW16: begin
                eq_w       = {2'b00, eq_16b};
                gtu_w      = {2'b00, gtu_16b};
                gts_w      = {2'b00, gts_16b};
                elem_valid = 4'b0011;
            end
            default: begin
                eq_w       = {3'b000, eq_32b};
                gtu_w      = {3'b000, gtu_32b};
                gts_w      = {3'b000, gts_32b};
                elem_valid = 4'b0001;
            end
        endcase
    end

    ////////////////////////////////////////
    // Compare select
    ////////////////////////////////////////

    always_comb begin
        case (op_i)
            vlane_pkg::VMSEQ:  cmp_sel = eq_w;
            vlane_pkg::VMSNE:  cmp_sel = ~eq_w;
            vlane_pkg::VMSLTU: cmp_sel = ~eq_w & ~gtu_w;
            vlane_pkg::VMSLT:  cmp_sel = ~eq_w & ~gts_w;
            vlane_pkg::VMSLEU: cmp_sel = ~gtu_w;
            vlane_pkg::VMSLE:  cmp_sel = ~gts_w;
            vlane_pkg::VMSGTU: cmp_sel = gtu_w;
            vlane_pkg::VMSGT:  cmp_sel = gts_w;
            default:           cmp_sel = 4'b0000;
        endcase
    end

    // Inverted flags must not leak above the element count
    assign cmp_o = cmp_sel & elem_valid;

    ////////////////////////////////////////
    // Min/max
    ////////////////////////////////////////

    always_comb begin
        logic use_signed;
        logic take_max;
        logic gt;
        use_signed = (op_i == vlane_pkg::VMIN) || (op_i == vlane_pkg::VMAX);
        take_max   = (op_i == vlane_pkg::VMAX) || (op_i == vlane_pkg::VMAXU);
        for (int b = 0; b < 4; b++) begin
            // Flag of the element that owns byte b
            case (vsew_i)
                vlane_pkg::EW8:  gt = use_signed ? gts_8b[b]    : gtu_8b[b];
                vlane_pkg::EW16: gt = use_signed ? gts_16b[b/2] : gtu_16b[b/2];
                default:         gt = use_signed ? gts_32b      : gtu_32b;
            endcase
            minmax_o[8*b +: 8] = (gt == take_max) ? first_i[8*b +: 8] : second_i[8*b +: 8];
        end
    end

endmodule

// ==== logic/lane_result.sv ====
`timescale 1ns/10ps

`include "vlane_cfg.svh"

module lane_result (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 enable_i,
    input  logic                                 vm_i,
    input  vlane_pkg::vop_e                      op_i,
    input  vlane_pkg::vsew_e                     vsew_i,
    input  vlane_pkg::slice_idx_t                slice_i,
    input  vlane_pkg::slice_t                    first_i,
    input  vlane_pkg::slice_t                    second_i,
    input  vlane_pkg::slice_t                    sum_i,
    input  vlane_pkg::slice_t                    shift_i,
    input  vlane_pkg::slice_t                    minmax_i,
    input  logic [3:0]                           cmp_i,
    input  logic [`VLANE_SLICE_ELEMS-1:0]        mask_i,
    output vlane_pkg::lane_t                     result_o,
    output vlane_pkg::mask_t                     result_mask_o
);

    localparam int SLICE_W = `VLANE_SLICE_W;

    vlane_pkg::slice_t result_and;
    vlane_pkg::slice_t result_or;
    vlane_pkg::slice_t result_xor;
    vlane_pkg::slice_t result_merge;
    vlane_pkg::slice_t slice_result;
    logic              is_cmp;
    logic [3:0]        cmp_active;
    vlane_pkg::mask_t  mask_next;

    ////////////////////////////////////////
    // Logic and merge
    ////////////////////////////////////////

    assign result_and = first_i & second_i;
    assign result_or  = first_i | second_i;
    assign result_xor = first_i ^ second_i;

    // Mask bit set takes second
    always_comb begin
        logic sel;
        for (int b = 0; b < 4; b++) begin
            case (vsew_i)
                vlane_pkg::EW8:  sel = mask_i[b];
                vlane_pkg::EW16: sel = mask_i[b/2];
                default:         sel = mask_i[0];
            endcase
            result_merge[8*b +: 8] = sel ? second_i[8*b +: 8] : first_i[8*b +: 8];
        end
    end

    ////////////////////////////////////////
    // Result select
    ////////////////////////////////////////

    always_comb begin
        case (op_i)
            vlane_pkg::VAND:   slice_result = result_and;
            vlane_pkg::VOR:    slice_result = result_or;
            vlane_pkg::VXOR:   slice_result = result_xor;
            vlane_pkg::VSLL,
            vlane_pkg::VSRL,
            vlane_pkg::VSRA:   slice_result = shift_i;
            vlane_pkg::VMIN,
            vlane_pkg::VMINU,
            vlane_pkg::VMAX,
            vlane_pkg::VMAXU:  slice_result = minmax_i;
            vlane_pkg::VMERGE: slice_result = result_merge;
            default:           slice_result = sum_i;
        endcase
    end

    assign is_cmp = op_i inside {vlane_pkg::VMSEQ,  vlane_pkg::VMSNE,
                                 vlane_pkg::VMSLTU, vlane_pkg::VMSLT,
                                 vlane_pkg::VMSLEU, vlane_pkg::VMSLE,
                                 vlane_pkg::VMSGTU, vlane_pkg::VMSGT};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_o <= '0;
        end
        else if (enable_i && !is_cmp) begin
            result_o[int'(slice_i)*SLICE_W +: SLICE_W] <= slice_result;
        end
    end

    ////////////////////////////////////////
    // Mask result
    ////////////////////////////////////////

    // Inactive elements read as zero unless vm_i is set
    assign cmp_active = cmp_i & ({4{vm_i}} | mask_i);

    // Slice 0 starts from a clear mask so bits above the element count stay zero
    always_comb begin
        mask_next = (slice_i == '0) ? '0 : result_mask_o;
        case (vsew_i)
            vlane_pkg::EW8:  mask_next[4*int'(slice_i) +: 4] = cmp_active;
            vlane_pkg::EW16: mask_next[2*int'(slice_i) +: 2] = cmp_active[1:0];
            default:         mask_next[int'(slice_i)]        = cmp_active[0];
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_mask_o <= '0;
        end
        else if (enable_i && is_cmp) begin
            result_mask_o <= mask_next;
        end
    end

endmodule

// ==== logic/vector_lane.sv ====
`timescale 1ns/10ps

`include "vlane_cfg.svh"

module vector_lane (
    input  logic              clk,
    input  logic              reset_n,
    input  vlane_pkg::lane_t  first_operand_i,
    input  vlane_pkg::lane_t  second_operand_i,
    input  vlane_pkg::mask_t  mask_i,
    input  logic              vm_i,
    input  logic              enable_i,
    input  vlane_pkg::vop_e   op_i,
    input  vlane_pkg::vsew_e  vsew_i,
    output logic              hold_o,
    output vlane_pkg::lane_t  result_o,
    output vlane_pkg::mask_t  result_mask_o
);

    localparam int SLICE_W = `VLANE_SLICE_W;
    localparam int ELEMS   = `VLANE_SLICE_ELEMS;

    vlane_pkg::slice_idx_t slice_idx;
    vlane_pkg::slice_t     first_slice;
    vlane_pkg::slice_t     second_slice;
    logic [ELEMS-1:0]      mask_slice;
    vlane_pkg::slice_t     sum;
    vlane_pkg::slice_t     shift;
    vlane_pkg::slice_t     minmax;
    logic [3:0]            cmp;

    ////////////////////////////////////////
    // Slice selection
    ////////////////////////////////////////

    lane_slice_counter slice_counter_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .enable_i (enable_i),
        .slice_o  (slice_idx),
        .hold_o   (hold_o)
    );

    assign first_slice  = first_operand_i [int'(slice_idx)*SLICE_W +: SLICE_W];
    assign second_slice = second_operand_i[int'(slice_idx)*SLICE_W +: SLICE_W];

    // Mask bits of the elements in the current slice
    always_comb begin
        case (vsew_i)
            vlane_pkg::EW8:  mask_slice = mask_i[4*int'(slice_idx) +: 4];
            vlane_pkg::EW16: mask_slice = {2'b00, mask_i[2*int'(slice_idx) +: 2]};
            default:         mask_slice = {3'b000, mask_i[int'(slice_idx)]};
        endcase
    end

    ////////////////////////////////////////
    // Datapath units
    ////////////////////////////////////////

    lane_adder adder_i (
        .op_i     (op_i),
        .vsew_i   (vsew_i),
        .first_i  (first_slice),
        .second_i (second_slice),
        .sum_o    (sum)
    );

    lane_shifter shifter_i (
        .op_i     (op_i),
        .vsew_i   (vsew_i),
        .first_i  (first_slice),
        .second_i (second_slice),
        .shift_o  (shift)
    );

    lane_compare compare_i (
        .op_i     (op_i),
        .vsew_i   (vsew_i),
        .first_i  (first_slice),
        .second_i (second_slice),
        .cmp_o    (cmp),
        .minmax_o (minmax)
    );

    lane_result result_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable_i),
        .vm_i          (vm_i),
        .op_i          (op_i),
        .vsew_i        (vsew_i),
        .slice_i       (slice_idx),
        .first_i       (first_slice),
        .second_i      (second_slice),
        .sum_i         (sum),
        .shift_i       (shift),
        .minmax_i      (minmax),
        .cmp_i         (cmp),
        .mask_i        (mask_slice),
        .result_o      (result_o),
        .result_mask_o (result_mask_o)
    );

endmodule

// ==== test/vector_lane_assertions.sv ====
`timescale 1ns/10ps

`include "vlane_cfg.svh"

module vector_lane_assertions (
    input logic                  clk,
    input logic                  reset_n,
    input logic                  enable_i,
    input logic                  hold_o,
    input vlane_pkg::slice_idx_t slice_idx_i,
    input vlane_pkg::lane_t      result_o,
    input vlane_pkg::mask_t      result_mask_o
);

    // Hold is only a qualifier of the enable level
    hold_needs_enable: assert property (
        @(posedge clk) disable iff (!reset_n) !enable_i |-> !hold_o
    ) else $error("hold_o high while enable_i is low");

    slice_in_range: assert property (
        @(posedge clk) disable iff (!reset_n) int'(slice_idx_i) <= `VLANE_SLICES - 1
    ) else $error("slice index beyond the last slice");

    ////////////////////////////////////////
    // Registers idle without enable
    ////////////////////////////////////////

    result_kept: assert property (
        @(posedge clk) disable iff (!reset_n) !enable_i |=> $stable(result_o)
    ) else $error("result_o changed on an edge with enable_i low");

    mask_kept: assert property (
        @(posedge clk) disable iff (!reset_n) !enable_i |=> $stable(result_mask_o)
    ) else $error("result_mask_o changed on an edge with enable_i low");

endmodule

bind vector_lane vector_lane_assertions assertions_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .enable_i      (enable_i),
    .hold_o        (hold_o),
    .slice_idx_i   (slice_idx),
    .result_o      (result_o),
    .result_mask_o (result_mask_o)
);

// ==== test/vector_lane_tb.sv ====
`timescale 1ns/10ps

`include "vlane_cfg.svh"

module vector_lane_tb;

    localparam int REPS           = 4;
    localparam int ARITH_OPS      = 3 * 3 * (REPS + 1);
    localparam int LOGIC_OPS      = 6 * 3 * REPS;
    localparam int MINMAX_OPS     = 5 * 3 * REPS * 2;
    localparam int CMP_OPS        = 8 * 3 * 2 * REPS;
    localparam int NUM_OPS        = ARITH_OPS + LOGIC_OPS + MINMAX_OPS + CMP_OPS;
    localparam int TIMEOUT_CYCLES = NUM_OPS * (`VLANE_SLICES + 2) + 10 + 50;

    logic             clk;
    logic             reset_n;
    vlane_pkg::lane_t first_operand;
    vlane_pkg::lane_t second_operand;
    vlane_pkg::mask_t mask;
    logic             vm;
    logic             enable;
    vlane_pkg::vop_e  op;
    vlane_pkg::vsew_e vsew;
    logic             hold;
    vlane_pkg::lane_t result;
    vlane_pkg::mask_t result_mask;

    // Expected register contents
    vlane_pkg::lane_t model_result;
    vlane_pkg::mask_t model_mask;

    logic [31:0] lcg_state;
    int          lane_errors;
    int          mask_errors;
    int          hold_errors;
    int          cycle_count = 0;

    vlane_pkg::vsew_e sews [3] = '{vlane_pkg::EW8, vlane_pkg::EW16, vlane_pkg::EW32};
    vlane_pkg::vop_e  arith_ops [3] = '{vlane_pkg::VADD, vlane_pkg::VSUB, vlane_pkg::VRSUB};
    vlane_pkg::vop_e  logic_ops [6] = '{vlane_pkg::VAND, vlane_pkg::VOR, vlane_pkg::VXOR,
                                        vlane_pkg::VSLL, vlane_pkg::VSRL, vlane_pkg::VSRA};
    vlane_pkg::vop_e  minmax_ops [5] = '{vlane_pkg::VMIN, vlane_pkg::VMINU, vlane_pkg::VMAX,
                                         vlane_pkg::VMAXU, vlane_pkg::VMERGE};
    vlane_pkg::vop_e  cmp_ops [8] = '{vlane_pkg::VMSEQ, vlane_pkg::VMSNE,
                                      vlane_pkg::VMSLTU, vlane_pkg::VMSLT,
                                      vlane_pkg::VMSLEU, vlane_pkg::VMSLE,
                                      vlane_pkg::VMSGTU, vlane_pkg::VMSGT};

    vector_lane vector_lane_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .first_operand_i  (first_operand),
        .second_operand_i (second_operand),
        .mask_i           (mask),
        .vm_i             (vm),
        .enable_i         (enable),
        .op_i             (op),
        .vsew_i           (vsew),
        .hold_o           (hold),
        .result_o         (result),
        .result_mask_o    (result_mask)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////
    // Random numbers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic vlane_pkg::lane_t random_lane();
        vlane_pkg::lane_t value;
        value[63:32] = lcg_next();
        value[31:0]  = lcg_next();
        return value;
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic int elem_width(vlane_pkg::vsew_e sew);
        case (sew)
            vlane_pkg::EW8:  return 8;
            vlane_pkg::EW16: return 16;
            default:         return 32;
        endcase
    endfunction

    function automatic logic [31:0] width_mask(int w);
        return (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
    endfunction

    // Element e zero extended
    function automatic logic [31:0] get_elem(vlane_pkg::lane_t lane, int e, int w);
        logic [63:0] shifted;
        shifted = lane >> (e * w);
        return shifted[31:0] & width_mask(w);
    endfunction

    function automatic int to_signed(logic [31:0] value, int w);
        int shifted;
        shifted = value << (32 - w);
        return shifted >>> (32 - w);
    endfunction

    function automatic logic is_compare(vlane_pkg::vop_e op_sel);
        return op_sel inside {vlane_pkg::VMSEQ,  vlane_pkg::VMSNE,
                              vlane_pkg::VMSLTU, vlane_pkg::VMSLT,
                              vlane_pkg::VMSLEU, vlane_pkg::VMSLE,
                              vlane_pkg::VMSGTU, vlane_pkg::VMSGT};
    endfunction

    function automatic vlane_pkg::lane_t expected_result(
        vlane_pkg::vop_e op_sel, vlane_pkg::vsew_e sew,
        vlane_pkg::lane_t a, vlane_pkg::lane_t b, vlane_pkg::mask_t m);
        vlane_pkg::lane_t res;
        logic [31:0]      x;
        logic [31:0]      y;
        logic [31:0]      r;
        int               w;
        int               amt;
        int               xs;
        int               ys;
        res = '0;
        w   = elem_width(sew);
        for (int e = 0; e < `VLANE_LLEN / w; e++) begin
            x   = get_elem(a, e, w);
            y   = get_elem(b, e, w);
            xs  = to_signed(x, w);
            ys  = to_signed(y, w);
            amt = y & (w - 1);
            case (op_sel)
                vlane_pkg::VADD:   r = x + y;
                vlane_pkg::VSUB:   r = x - y;
                vlane_pkg::VRSUB:  r = y - x;
                vlane_pkg::VAND:   r = x & y;
                vlane_pkg::VOR:    r = x | y;
                vlane_pkg::VXOR:   r = x ^ y;
                vlane_pkg::VSLL:   r = x << amt;
                vlane_pkg::VSRL:   r = x >> amt;
                vlane_pkg::VSRA:   r = xs >>> amt;
                vlane_pkg::VMIN:   r = (xs < ys) ? x : y;
                vlane_pkg::VMINU:  r = (x < y) ? x : y;
                vlane_pkg::VMAX:   r = (xs > ys) ? x : y;
                vlane_pkg::VMAXU:  r = (x > y) ? x : y;
                vlane_pkg::VMERGE: r = m[e] ? y : x;
                default:           r = '0;
            endcase
            res = res | (vlane_pkg::lane_t'(r & width_mask(w)) << (e * w));
        end
        return res;
    endfunction

    // Elements beyond the count keep a zero bit
    function automatic vlane_pkg::mask_t expected_mask(
        vlane_pkg::vop_e op_sel, vlane_pkg::vsew_e sew,
        vlane_pkg::lane_t a, vlane_pkg::lane_t b, vlane_pkg::mask_t m, logic vm_bit);
        vlane_pkg::mask_t res;
        logic [31:0]      x;
        logic [31:0]      y;
        int               w;
        int               xs;
        int               ys;
        logic             hit;
        res = '0;
        w   = elem_width(sew);
        for (int e = 0; e < `VLANE_LLEN / w; e++) begin
            x  = get_elem(a, e, w);
            y  = get_elem(b, e, w);
            xs = to_signed(x, w);
            ys = to_signed(y, w);
            case (op_sel)
                vlane_pkg::VMSEQ:  hit = (x == y);
                vlane_pkg::VMSNE:  hit = (x != y);
                vlane_pkg::VMSLTU: hit = (x < y);
                vlane_pkg::VMSLT:  hit = (xs < ys);
                vlane_pkg::VMSLEU: hit = (x <= y);
                vlane_pkg::VMSLE:  hit = (xs <= ys);
                vlane_pkg::VMSGTU: hit = (x > y);
                vlane_pkg::VMSGT:  hit = (xs > ys);
                default:           hit = 1'b0;
            endcase
            res[e] = hit & (vm_bit | m[e]);
        end
        return res;
    endfunction

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_lane(input string name, input vlane_pkg::lane_t expected,
                              input vlane_pkg::lane_t actual);
        if (actual !== expected) begin
            lane_errors++;
            $display("[ERROR] %s expected 0x%h actual 0x%h (op %s, sew %s)",
                     name, expected, actual, op.name(), vsew.name());
        end
    endtask

    task automatic check_mask(input string name, input vlane_pkg::mask_t expected,
                              input vlane_pkg::mask_t actual);
        if (actual !== expected) begin
            mask_errors++;
            $display("[ERROR] %s expected 0x%h actual 0x%h (op %s, sew %s)",
                     name, expected, actual, op.name(), vsew.name());
        end
    endtask

    task automatic check_hold(input logic expected, input logic actual);
        if (actual !== expected) begin
            hold_errors++;
            $display("[ERROR] hold_o expected 0x%h actual 0x%h", expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // One operation over all slices with outputs sampled on the falling edge
    task automatic run_op(input vlane_pkg::vop_e op_sel, input vlane_pkg::vsew_e sew,
                          input vlane_pkg::lane_t a, input vlane_pkg::lane_t b,
                          input vlane_pkg::mask_t m, input logic vm_bit);
        int hold_cycles;
        hold_cycles = 0;
        @(posedge clk);
        first_operand  <= a;
        second_operand <= b;
        mask           <= m;
        vm             <= vm_bit;
        op             <= op_sel;
        vsew           <= sew;
        enable         <= 1'b1;
        @(negedge clk);
        while (hold) begin
            hold_cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        enable <= 1'b0;
        if (is_compare(op_sel)) begin
            model_mask = expected_mask(op_sel, sew, a, b, m, vm_bit);
        end
        else begin
            model_result = expected_result(op_sel, sew, a, b, m);
        end
        @(negedge clk);
        if (hold_cycles != `VLANE_SLICES - 1) begin
            hold_errors++;
            $display("hold_o stayed high for %0d cycles on %s, expected %0d",
                     hold_cycles, op_sel.name(), `VLANE_SLICES - 1);
        end
        check_lane("result_o", model_result, result);
        check_mask("result_mask_o", model_mask, result_mask);
    endtask

    task automatic compare_sweep();
        vlane_pkg::lane_t a;
        vlane_pkg::lane_t b;
        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 8; o++) begin
                for (int v = 0; v < 2; v++) begin
                    for (int r = 0; r < REPS; r++) begin
                        a = random_lane();
                        b = random_lane();
                        // Some equal elements in the low slice
                        if (r == 0) begin
                            b[31:0] = a[31:0];
                        end
                        run_op(cmp_ops[o], sews[s], a, b,
                               vlane_pkg::mask_t'(lcg_next()), v[0]);
                    end
                end
            end
        end
    endtask

    task automatic arith_sweep();
        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 3; o++) begin
                // Carries and borrows that would cross element boundaries
                run_op(arith_ops[o], sews[s], 64'h00ff_ff00_ffff_0000,
                       64'h0101_0101_0101_0101, '0, 1'b0);
                for (int r = 0; r < REPS; r++) begin
                    run_op(arith_ops[o], sews[s], random_lane(), random_lane(), '0, 1'b0);
                end
            end
        end
    endtask

    task automatic logic_sweep();
        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 6; o++) begin
                for (int r = 0; r < REPS; r++) begin
                    run_op(logic_ops[o], sews[s], random_lane(), random_lane(), '0, 1'b0);
                end
            end
        end
    endtask

    // Each min/max or merge is followed by a compare
    task automatic minmax_sweep();
        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 5; o++) begin
                for (int r = 0; r < REPS; r++) begin
                    run_op(minmax_ops[o], sews[s], random_lane(), random_lane(),
                           vlane_pkg::mask_t'(lcg_next()), 1'b0);
                    run_op(cmp_ops[lcg_next() % 8], sews[s], random_lane(), random_lane(),
                           vlane_pkg::mask_t'(lcg_next()), 1'b1);
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        lcg_state      = 32'h0bf3_502a;
        lane_errors    = 0;
        mask_errors    = 0;
        hold_errors    = 0;
        model_result   = '0;
        model_mask     = '0;
        clk            = 1'b0;
        reset_n        = 1'b0;
        first_operand  = '0;
        second_operand = '0;
        mask           = '0;
        vm             = 1'b0;
        enable         = 1'b0;
        op             = vlane_pkg::VADD;
        vsew           = vlane_pkg::EW8;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_lane("result_o", '0, result);
        check_mask("result_mask_o", '0, result_mask);
        check_hold(1'b0, hold);
        compare_sweep();
        arith_sweep();
        logic_sweep();
        minmax_sweep();
        $display("Errors: result %0d, mask %0d, hold %0d", lane_errors, mask_errors,
                 hold_errors);
        if (lane_errors + mask_errors + hold_errors == 0) begin
            $display("TEST PASSED");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

// ==== src.f ====
+incdir+logic
logic/vlane_pkg.sv
logic/lane_slice_counter.sv
logic/lane_adder.sv
logic/lane_shifter.sv
logic/lane_compare.sv
logic/lane_result.sv
logic/vector_lane.sv
test/vector_lane_assertions.sv
test/vector_lane_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module vector_lane_tb -f src.f -o vector_lane_sim

status=0
./obj_dir/vector_lane_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
